// File: rv_decode_pkg.sv
package rv_decode_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  // funct7 of the M extension
  localparam logic [6:0] M_FUNCT7 = 7'b000_0001;

  // MISCMEM funct3 for fence.i
  localparam logic [2:0] FENCEI_F3 = 3'b001;

  // imm[11:0] of the PRIV group
  localparam logic [11:0] IMM_ECALL  = 12'h000;
  localparam logic [11:0] IMM_EBREAK = 12'h001;
  localparam logic [11:0] IMM_WFI    = 12'h105;
  localparam logic [11:0] IMM_MRET   = 12'h302;

  typedef enum logic [6:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    IMMED    = 7'b0010011,
    REGREG   = 7'b0110011,
    MISCMEM  = 7'b0001111,
    SYSTEM   = 7'b1110011,
    // decoded only to be flagged illegal
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111
  } opcode_t;

  // shared by IMMED and REGREG
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_funct3_t;

  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } sys_funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // five sources do not fit in two bits
  typedef enum logic [2:0] {
    LOAD_SRC, JUMP_SRC, LUI_SRC, ALU_SRC, CSR_SRC
  } w_src_t;

  typedef enum logic [1:0] {ARITH, MUL, DIV, LOADSTORE} fu_type_t;

  typedef enum logic [1:0] {SIGNED, UNSIGNED, SIGNED_UNSIGNED} sign_type_t;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_t               opcode;
  } instr_t;

  typedef struct packed {
    logic [11:0]           imm_i;
    logic [11:0]           imm_s;
    logic [12:0]           imm_sb;
    logic [20:0]           imm_uj;
    logic [XLEN-1:0]       imm_u;
    logic [4:0]            shamt;
    logic                  shamt_sel;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
  } imm_bundle_t;

  typedef struct packed {
    alu_op_t    alu_op;
    logic [1:0] src_a_sel;
    logic [1:0] src_b_sel;
    w_src_t     w_src;
    logic       wen;
    logic       branch;
    logic [2:0] branch_type;
    logic       jump;
    logic       j_sel;
    logic       lui;
  } exec_ctrl_t;

  typedef struct packed {
    fu_type_t   fu_type;
    logic       mul_high;
    sign_type_t sign_type;
    logic       div_quotient;
    logic [2:0] load_type;
    logic       dren;
    logic       dwen;
  } fu_ctrl_t;

  typedef struct packed {
    logic                  csr_instr;
    logic                  csr_swap;
    logic                  csr_set;
    logic                  csr_clr;
    logic                  csr_imm;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       zimm;
    logic                  mret;
    logic                  ebreak;
    logic                  ecall;
    logic                  wfi;
    logic                  ifence;
  } sys_ctrl_t;

endpackage

// File: imm_gen.sv
`timescale 1ns/100ps

module imm_gen import rv_decode_pkg::*; (
  input  instr_t      instr_i,
  output imm_bundle_t imm_o
);

  logic [XLEN-1:0] w;

  assign w = instr_i;

  // register indices sit at fixed positions in every format
  assign imm_o.rs1   = instr_i.rs1;
  assign imm_o.rs2   = instr_i.rs2;
  assign imm_o.rd    = instr_i.rd;
  assign imm_o.shamt = w[24:20];

  // sign bit stays in the msb of each field
  assign imm_o.imm_i  = w[31:20];
  assign imm_o.imm_s  = {w[31:25], w[11:7]};
  assign imm_o.imm_sb = {w[31], w[7], w[30:25], w[11:8], 1'b0};
  assign imm_o.imm_uj = {w[31], w[19:12], w[20], w[30:21], 1'b0};
  assign imm_o.imm_u  = {w[31:12], 12'b0};

  // immediate shifts take shamt instead of imm_i
  assign imm_o.shamt_sel = (instr_i.opcode == IMMED) &&
                           (instr_i.funct3 == F3_SLL || instr_i.funct3 == F3_SR);

endmodule

// File: exec_decode.sv
`timescale 1ns/100ps

module exec_decode import rv_decode_pkg::*; (
  input  instr_t     instr_i,
  input  logic       csr_rw_i,
  output exec_ctrl_t exec_o
);

  logic is_imm, is_reg, is_ar, b30;
  logic op_sll, op_sra, op_srl, op_add, op_sub;
  logic op_and, op_or, op_xor, op_slt, op_sltu;

  assign is_imm = (instr_i.opcode == IMMED);
  assign is_reg = (instr_i.opcode == REGREG);
  assign is_ar  = is_imm || is_reg;
  // splits sub from add and sra from srl
  assign b30    = instr_i.funct7[5];

  assign op_sll  = is_ar && instr_i.funct3 == F3_SLL;
  assign op_sra  = is_ar && instr_i.funct3 == F3_SR && b30;
  assign op_srl  = is_ar && instr_i.funct3 == F3_SR && !b30;
  assign op_add  = (is_imm && instr_i.funct3 == F3_ADD) ||
                   (is_reg && instr_i.funct3 == F3_ADD && !b30) ||
                   instr_i.opcode inside {AUIPC, LOAD, STORE};
  assign op_sub  = is_reg && instr_i.funct3 == F3_ADD && b30;
  assign op_and  = is_ar && instr_i.funct3 == F3_AND;
  assign op_or   = is_ar && instr_i.funct3 == F3_OR;
  assign op_xor  = is_ar && instr_i.funct3 == F3_XOR;
  assign op_slt  = is_ar && instr_i.funct3 == F3_SLT;
  assign op_sltu = is_ar && instr_i.funct3 == F3_SLTU;

  always_comb begin
    if (op_sll)       exec_o.alu_op = ALU_SLL;
    else if (op_sra)  exec_o.alu_op = ALU_SRA;
    else if (op_srl)  exec_o.alu_op = ALU_SRL;
    else if (op_add)  exec_o.alu_op = ALU_ADD;
    else if (op_sub)  exec_o.alu_op = ALU_SUB;
    else if (op_and)  exec_o.alu_op = ALU_AND;
    else if (op_or)   exec_o.alu_op = ALU_OR;
    else if (op_xor)  exec_o.alu_op = ALU_XOR;
    else if (op_slt)  exec_o.alu_op = ALU_SLT;
    else if (op_sltu) exec_o.alu_op = ALU_SLTU;
    else              exec_o.alu_op = ALU_ADD;
  end

  // operand selects, write-back source and write enable by opcode
  always_comb begin
    exec_o.src_a_sel = 2'd2;
    exec_o.src_b_sel = 2'd1;
    exec_o.w_src     = LOAD_SRC;
    exec_o.wen       = 1'b0;
    case (instr_i.opcode)
      REGREG, IMMED, LOAD, BRANCH, JALR, SYSTEM: exec_o.src_a_sel = 2'd0;
      STORE:                                     exec_o.src_a_sel = 2'd1;
      default: ;
    endcase
    case (instr_i.opcode)
      STORE:       exec_o.src_b_sel = 2'd0;
      IMMED, LOAD: exec_o.src_b_sel = 2'd2;
      AUIPC:       exec_o.src_b_sel = 2'd3;
      default: ;
    endcase
    case (instr_i.opcode)
      JAL, JALR:            exec_o.w_src = JUMP_SRC;
      LUI:                  exec_o.w_src = LUI_SRC;
      IMMED, AUIPC, REGREG: exec_o.w_src = ALU_SRC;
      SYSTEM:               exec_o.w_src = CSR_SRC;
      default: ;
    endcase
    case (instr_i.opcode)
      IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD: exec_o.wen = 1'b1;
      // csr ops write rd with the old csr value
      SYSTEM:                                     exec_o.wen = csr_rw_i;
      default: ;
    endcase
  end

  assign exec_o.branch      = (instr_i.opcode == BRANCH);
  assign exec_o.branch_type = instr_i.funct3;
  assign exec_o.jump        = (instr_i.opcode == JAL) || (instr_i.opcode == JALR);
  assign exec_o.j_sel       = (instr_i.opcode == JAL);
  assign exec_o.lui         = (instr_i.opcode == LUI);

endmodule

// File: fu_dispatch_decode.sv
`timescale 1ns/100ps

module fu_dispatch_decode import rv_decode_pkg::*; (
  input  instr_t   instr_i,
  output fu_ctrl_t fu_o,
  output logic     illegal_o
);

  logic is_m;

  assign is_m = (instr_i.opcode == REGREG) && (instr_i.funct7 == M_FUNCT7);

  always_comb begin
    if (is_m) begin
      fu_o.fu_type = instr_i.funct3[2] ? DIV : MUL;
    end else if (instr_i.opcode == LOAD || instr_i.opcode == STORE) begin
      fu_o.fu_type = LOADSTORE;
    end else begin
      fu_o.fu_type = ARITH;
    end
  end

  // shared by mul and div
  always_comb begin
    case (instr_i.funct3)
      3'b011, 3'b101, 3'b111: fu_o.sign_type = UNSIGNED;
      3'b010:                 fu_o.sign_type = SIGNED_UNSIGNED;
      default:                fu_o.sign_type = SIGNED;
    endcase
  end

  // upper half for mulh, mulhsu, mulhu
  assign fu_o.mul_high     = |instr_i.funct3[1:0];
  // div and divu return the quotient
  assign fu_o.div_quotient = is_m && instr_i.funct3[2] && !instr_i.funct3[1];

  assign fu_o.load_type = instr_i.funct3;
  assign fu_o.dren      = (instr_i.opcode == LOAD);
  assign fu_o.dwen      = (instr_i.opcode == STORE);

  always_comb begin
    case (instr_i.opcode)
      REGREG: illegal_o = instr_i.funct7[0] && !is_m;
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
      IMMED, MISCMEM, SYSTEM: illegal_o = 1'b0;
      VECTOR, LOAD_FP, STORE_FP: illegal_o = 1'b1;
      // all-zero opcode passes as a bubble
      default: illegal_o = (instr_i.opcode != 7'b0);
    endcase
  end

  // M-unit dispatch only for a legal REGREG word
  always_comb begin
    assert (!(fu_o.fu_type inside {MUL, DIV}) ||
            (instr_i.opcode == REGREG && !illegal_o))
      else $error("mul/div dispatch outside a legal REGREG");
  end

endmodule

// File: system_decode.sv
`timescale 1ns/100ps

module system_decode import rv_decode_pkg::*; (
  input  instr_t    instr_i,
  output sys_ctrl_t sys_o,
  output logic      csr_rw_o
);

  logic        is_sys;
  logic [11:0] imm12;

  assign is_sys = (instr_i.opcode == SYSTEM);
  assign imm12  = {instr_i.funct7, instr_i.rs2};

  always_comb begin
    sys_o.csr_swap = 1'b0;
    sys_o.csr_set  = 1'b0;
    sys_o.csr_clr  = 1'b0;
    sys_o.csr_imm  = 1'b0;
    if (is_sys) begin
      case (instr_i.funct3)
        CSRRW:  sys_o.csr_swap = 1'b1;
        CSRRS:  sys_o.csr_set  = 1'b1;
        CSRRC:  sys_o.csr_clr  = 1'b1;
        CSRRWI: begin
          sys_o.csr_swap = 1'b1;
          sys_o.csr_imm  = 1'b1;
        end
        CSRRSI: begin
          sys_o.csr_set = 1'b1;
          sys_o.csr_imm = 1'b1;
        end
        CSRRCI: begin
          sys_o.csr_clr = 1'b1;
          sys_o.csr_imm = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign csr_rw_o        = sys_o.csr_swap | sys_o.csr_set | sys_o.csr_clr;
  assign sys_o.csr_instr = is_sys;
  assign sys_o.csr_addr  = imm12;
  // rs1 field doubles as the 5-bit csr immediate
  assign sys_o.zimm      = {{(XLEN - REG_ADDR_W){1'b0}}, instr_i.rs1};

  // priv group is told apart by imm[11:0]
  always_comb begin
    sys_o.mret   = 1'b0;
    sys_o.ebreak = 1'b0;
    sys_o.ecall  = 1'b0;
    sys_o.wfi    = 1'b0;
    if (is_sys && instr_i.funct3 == PRIV) begin
      sys_o.mret   = (imm12 == IMM_MRET);
      sys_o.ebreak = (imm12 == IMM_EBREAK);
      sys_o.ecall  = (imm12 == IMM_ECALL);
      sys_o.wfi    = (imm12 == IMM_WFI);
    end
  end

  assign sys_o.ifence = (instr_i.opcode == MISCMEM) && (instr_i.funct3 == FENCEI_F3);

  // csr op is one-hot and never mixes with a priv instruction
  always_comb begin
    assert ($onehot0({sys_o.csr_swap, sys_o.csr_set, sys_o.csr_clr}) &&
            !(csr_rw_o && (sys_o.mret || sys_o.ecall || sys_o.ebreak || sys_o.wfi)))
      else $error("conflicting csr decode");
  end

endmodule

// File: rv_decode.sv
`timescale 1ns/100ps

module rv_decode import rv_decode_pkg::*; (
  input  logic        CLK,
  input  logic        reset_i,
  input  logic        valid_i,
  input  instr_t      instr_i,
  output logic        valid_o,
  output imm_bundle_t imm_o,
  output exec_ctrl_t  exec_o,
  output fu_ctrl_t    fu_o,
  output sys_ctrl_t   sys_o,
  output logic        illegal_o
);

  imm_bundle_t imm_d;
  exec_ctrl_t  exec_d;
  fu_ctrl_t    fu_d;
  sys_ctrl_t   sys_d;
  logic        illegal_d;
  logic        csr_rw;

  imm_gen i_imm_gen (
    .instr_i (instr_i),
    .imm_o   (imm_d)
  );

  exec_decode i_exec_decode (
    .instr_i  (instr_i),
    .csr_rw_i (csr_rw),
    .exec_o   (exec_d)
  );

  fu_dispatch_decode i_fu_dispatch_decode (
    .instr_i   (instr_i),
    .fu_o      (fu_d),
    .illegal_o (illegal_d)
  );

  system_decode i_system_decode (
    .instr_i  (instr_i),
    .sys_o    (sys_d),
    .csr_rw_o (csr_rw)
  );

  // one stage; payload only loads on a valid word
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      valid_o          <= 1'b0;
      illegal_o        <= 1'b0;
      exec_o.wen       <= 1'b0;
      exec_o.branch    <= 1'b0;
      exec_o.jump      <= 1'b0;
      exec_o.j_sel     <= 1'b0;
      exec_o.lui       <= 1'b0;
      fu_o.dren        <= 1'b0;
      fu_o.dwen        <= 1'b0;
      sys_o.csr_instr  <= 1'b0;
      sys_o.csr_swap   <= 1'b0;
      sys_o.csr_set    <= 1'b0;
      sys_o.csr_clr    <= 1'b0;
      sys_o.csr_imm    <= 1'b0;
      sys_o.mret       <= 1'b0;
      sys_o.ebreak     <= 1'b0;
      sys_o.ecall      <= 1'b0;
      sys_o.wfi        <= 1'b0;
      sys_o.ifence     <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        imm_o     <= imm_d;
        exec_o    <= exec_d;
        fu_o      <= fu_d;
        sys_o     <= sys_d;
        illegal_o <= illegal_d;
      end
    end
  end

  // valid_o only ever follows an accepted word from the cycle before
  assert property (@(posedge CLK) valid_o |-> $past(valid_i && !reset_i))
    else $error("valid_o without an accepted instruction");

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: tb_rv_decode.sv
`timescale 1ns/100ps

module tb_rv_decode import rv_decode_pkg::*; ();

  localparam int NUM_PAT      = 29;
  localparam int NUM_COL      = 12;
  localparam int RESET_CYCLES = 5;
  // one idle cycle at most per pattern plus the tail cycle
  localparam int MAX_CYCLES   = 2 * NUM_PAT + RESET_CYCLES + 20;

  logic        clk;
  logic        reset_i;
  logic        valid_i;
  instr_t      instr_i;
  logic        valid_o;
  imm_bundle_t imm_o;
  exec_ctrl_t  exec_o;
  fu_ctrl_t    fu_o;
  sys_ctrl_t   sys_o;
  logic        illegal_o;

  logic [31:0] pat_mem [NUM_PAT * NUM_COL];
  logic [7:0]  lfsr_state;
  int          cycle_count;

  tb_clk_gen #(.PERIOD_NS(10)) i_tb_clk_gen (.clk_o(clk));

  rv_decode i_rv_decode (
    .CLK       (clk),
    .reset_i   (reset_i),
    .valid_i   (valid_i),
    .instr_i   (instr_i),
    .valid_o   (valid_o),
    .imm_o     (imm_o),
    .exec_o    (exec_o),
    .fu_o      (fu_o),
    .sys_o     (sys_o),
    .illegal_o (illegal_o)
  );

  // galois form of x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    logic [7:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 8'hB8;
    return n;
  endfunction

  task automatic next_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %0h expected %0h", $time, name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_reset_state();
    check_value("valid_o in reset", 32'(valid_o), 32'd0);
    check_value("control flags in reset",
                32'({illegal_o, exec_o.wen, exec_o.branch, exec_o.jump, fu_o.dren,
                     fu_o.dwen, sys_o.csr_swap, sys_o.csr_set, sys_o.csr_clr,
                     sys_o.csr_imm, sys_o.mret, sys_o.ebreak, sys_o.ecall, sys_o.wfi,
                     sys_o.ifence}), 32'd0);
  endtask

  task automatic check_pattern(input int p);
    int          base;
    logic [31:0] fu_exp;
    logic [31:0] imm_act;
    base = p * NUM_COL;
    check_value("valid_o", 32'(valid_o), 32'd1);
    check_value("alu_op", 32'(exec_o.alu_op), pat_mem[base + 1]);
    check_value("wen", 32'(exec_o.wen), pat_mem[base + 2]);
    check_value("w_src", 32'(exec_o.w_src), pat_mem[base + 3]);
    check_value("operand selects", 32'({exec_o.src_a_sel, exec_o.src_b_sel}),
                pat_mem[base + 4]);
    check_value("fu_type", 32'(fu_o.fu_type), pat_mem[base + 5]);
    check_value("illegal", 32'(illegal_o), pat_mem[base + 7]);
    check_value("csr op", 32'({sys_o.csr_swap, sys_o.csr_set, sys_o.csr_clr,
                               sys_o.csr_imm}), pat_mem[base + 8]);
    check_value("priv flags", 32'({sys_o.mret, sys_o.ebreak, sys_o.ecall, sys_o.wfi,
                                   sys_o.ifence}), pat_mem[base + 9]);
    fu_exp = pat_mem[base + 5];
    if (fu_exp == 32'(MUL) || fu_exp == 32'(DIV))
      check_value("mul/div controls",
                  32'({fu_o.mul_high, fu_o.sign_type, fu_o.div_quotient}),
                  pat_mem[base + 6] & 32'hF);
    if (fu_exp == 32'(LOADSTORE))
      check_value("load_type", 32'(fu_o.load_type), (pat_mem[base + 6] >> 4) & 32'h7);
    // column 10 says which field the immediate column describes
    case (pat_mem[base + 10])
      32'd1: begin
        check_value("shamt_sel", 32'(imm_o.shamt_sel), 32'd0);
        imm_act = {{20{imm_o.imm_i[11]}}, imm_o.imm_i};
      end
      32'd2: imm_act = {{20{imm_o.imm_s[11]}}, imm_o.imm_s};
      32'd3: imm_act = {{19{imm_o.imm_sb[12]}}, imm_o.imm_sb};
      32'd4: imm_act = {{11{imm_o.imm_uj[20]}}, imm_o.imm_uj};
      32'd5: imm_act = imm_o.imm_u;
      32'd6: begin
        check_value("shamt_sel", 32'(imm_o.shamt_sel), 32'd1);
        imm_act = 32'(imm_o.shamt);
      end
      32'd7: imm_act = sys_o.zimm;
      default: imm_act = 32'd0;
    endcase
    if (pat_mem[base + 10] != 32'd0)
      check_value("immediate", imm_act, pat_mem[base + 11]);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int         p;
    logic       idle;
    logic       last_idle;
    exec_ctrl_t hold_exec;
    imm_bundle_t hold_imm;
    fu_ctrl_t   hold_fu;
    sys_ctrl_t  hold_sys;
    logic       hold_illegal;
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    instr_i     = '0;
    cycle_count = 0;
    lfsr_state  = 8'd80;
    last_idle   = 1'b0;
    p           = 0;
    // marker in the last format column shows a short or missing file
    pat_mem[(NUM_PAT - 1) * NUM_COL + 10] = 32'hFFFF_FFFF;
    $readmemh("decode_patterns.txt", pat_mem);
    if (pat_mem[(NUM_PAT - 1) * NUM_COL + 10] > 32'd7) begin
      $display("decode_patterns.txt is missing or holds too few patterns");
      $display(">>> FAIL");
      $fatal(1, "pattern file");
    end

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    reset_i = 1'b0;

    while (p < NUM_PAT) begin
      next_bit(idle);
      if (idle && !last_idle) begin
        hold_exec    = exec_o;
        hold_imm     = imm_o;
        hold_fu      = fu_o;
        hold_sys     = sys_o;
        hold_illegal = illegal_o;
        valid_i      = 1'b0;
        instr_i      = instr_t'(32'hFFFF_FFFF);
        @(posedge clk);
        #1;
        check_value("valid_o after idle", 32'(valid_o), 32'd0);
        check_value("payload hold",
                    32'(hold_exec != exec_o || hold_imm != imm_o || hold_fu != fu_o ||
                        hold_sys != sys_o || hold_illegal != illegal_o), 32'd0);
        last_idle = 1'b1;
      end else begin
        valid_i = 1'b1;
        instr_i = instr_t'(pat_mem[p * NUM_COL]);
        @(posedge clk);
        #1;
        check_pattern(p);
        p         = p + 1;
        last_idle = 1'b0;
      end
    end

    valid_i = 1'b0;
    @(posedge clk);
    #1;
    check_value("valid_o at end", 32'(valid_o), 32'd0);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: files.f
rv_decode_pkg.sv
imm_gen.sv
exec_decode.sv
fu_dispatch_decode.sv
system_decode.sv
rv_decode.sv
tb_clk_gen.sv
tb_rv_decode.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_decode -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: decode_patterns.txt
// instr alu_op wen w_src {src_a,src_b} fu_type {load_type,mul_high,sign,div_q}
// illegal {swap,set,clr,imm} {mret,ebreak,ecall,wfi,ifence} imm_fmt imm_value
FFB10093 0 1 3 2 0 00 0 0 00 1 FFFFFFFB // addi x1, x2, -5
405201B3 1 1 3 1 0 00 0 0 00 0 00000000 // sub x3, x4, x5
4083D333 4 1 3 1 0 00 0 0 00 0 00000000 // sra x6, x7, x8
00755493 3 1 3 2 0 00 0 0 00 6 00000007 // srli x9, x10, 7
00D635B3 9 1 3 1 0 00 0 0 00 0 00000000 // sltu x11, x12, x13
01F09093 2 1 3 2 0 00 0 0 00 6 0000001F // slli x1, x1, 31
FFC32283 0 1 0 2 3 20 0 0 00 1 FFFFFFFC // lw x5, -4(x6)
00814383 0 1 0 2 3 40 0 0 00 1 00000008 // lbu x7, 8(x2)
FE952C23 0 0 0 4 3 20 0 0 00 2 FFFFFFF8 // sw x9, -8(x10)
FE2088E3 0 0 0 1 0 00 0 0 00 3 FFFFFFF0 // beq x1, x2, -16
801FF0EF 0 1 1 9 0 00 0 0 00 4 FFFFF800 // jal x1, -2048
FFFFF2B7 0 1 2 9 0 00 0 0 00 5 FFFFF000 // lui x5, 0xfffff
80000197 0 1 3 B 0 00 0 0 00 5 80000000 // auipc x3, 0x80000
023100B3 0 1 3 1 1 00 0 0 00 0 00000000 // mul x1, x2, x3
0262B233 9 1 3 1 1 0A 0 0 00 0 00000000 // mulhu x4, x5, x6
029443B3 7 1 3 1 2 01 0 0 00 0 00000000 // div x7, x8, x9
02C5F533 5 1 3 1 2 0A 0 0 00 0 00000000 // remu x10, x11, x12
305110F3 0 1 4 1 0 00 0 8 00 7 00000002 // csrrw x1, mtvec, x2
300461F3 0 1 4 1 0 00 0 5 00 7 00000008 // csrrsi x3, mstatus, 8
342332F3 0 1 4 1 0 00 0 2 00 7 00000006 // csrrc x5, mcause, x6
30200073 0 0 4 1 0 00 0 0 10 0 00000000 // mret
00000073 0 0 4 1 0 00 0 0 04 0 00000000 // ecall
00100073 0 0 4 1 0 00 0 0 08 0 00000000 // ebreak
10500073 0 0 4 1 0 00 0 0 02 0 00000000 // wfi
0000100F 0 0 0 9 0 00 0 0 01 0 00000000 // fence.i
00000057 0 0 0 9 0 00 1 0 00 0 00000000 // vector opcode
063100B3 0 1 3 1 0 00 1 0 00 0 00000000 // regreg with funct7 3
0000007F 0 0 0 9 0 00 1 0 00 0 00000000 // unknown opcode
00000000 0 0 0 9 0 00 0 0 00 0 00000000 // all-zero word
